/* design/fft_agu.sv */
`timescale 1ns/1ps

module fft_agu (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                start,
    output fft_pkg::bfly_addr_t rd_pair,
    output logic                rd_en,
    output fft_pkg::tw_idx_t    tw_idx,
    output fft_pkg::bfly_addr_t wr_pair,
    output logic                wr_en,
    output logic                busy,
    output logic                done
);

    fft_pkg::agu_state_e state;
    fft_pkg::level_t     level;
    fft_pkg::bfly_idx_t  idx;
    logic                drain_cnt;
    logic                last_level;

    fft_pkg::addr_t      tw_mask;
    fft_pkg::addr_t      tw_full;

    fft_pkg::bfly_addr_t pair_d1;
    logic                en_d1;

    // 5-bit rotate left by the level.
    function automatic fft_pkg::addr_t rotl(fft_pkg::addr_t v, fft_pkg::level_t s);
        logic [9:0] both;
        both = {v, v} << s;
        return both[9:5];
    endfunction

    assign last_level = (level == fft_pkg::level_t'(fft_pkg::fft_levels - 1));

    // ------------------------------------------------------------------------
    // level and index sequencing.
    // ------------------------------------------------------------------------

    // 16 reads, then 2 drain cycles so the last writes land before the swap.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= fft_pkg::idle;
            level     <= '0;
            idx       <= '0;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                fft_pkg::idle: begin
                    if (start) begin
                        state <= fft_pkg::run;
                        level <= '0;
                        idx   <= '0;
                    end
                end
                fft_pkg::run: begin
                    idx <= idx + 1'b1;
                    if (idx == '1) begin
                        state     <= fft_pkg::drain;
                        drain_cnt <= 1'b0;
                    end
                end
                fft_pkg::drain: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        if (last_level) begin
                            state <= fft_pkg::finish;
                        end else begin
                            state <= fft_pkg::run;
                            level <= level + 1'b1;
                        end
                    end
                end
                default: state <= fft_pkg::idle;
            endcase
        end
    end

    assign rd_en = (state == fft_pkg::run);
    assign busy  = (state == fft_pkg::run) || (state == fft_pkg::drain);
    assign done  = (state == fft_pkg::finish);

    // ------------------------------------------------------------------------
    // addresses and twiddle index.
    // ------------------------------------------------------------------------

    // pair differs only in bit level; banks swap every level.
    assign rd_pair.a    = rotl({idx, 1'b0}, level);
    assign rd_pair.b    = rotl({idx, 1'b1}, level);
    assign rd_pair.bank = level[0];

    // (a mod 2^L) scaled up by 2^(4-L).
    assign tw_mask = fft_pkg::addr_t'((1 << level) - 1);
    assign tw_full = (rd_pair.a & tw_mask) << (3'd4 - level);
    assign tw_idx  = fft_pkg::tw_idx_t'(tw_full);

    // write side trails the read by memory plus butterfly latency.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            en_d1 <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            en_d1 <= rd_en;
            wr_en <= en_d1;
        end
    end

    always_ff @(posedge clock) begin
        pair_d1 <= rd_pair;
        wr_pair <= pair_d1;
    end

endmodule

/* design/fft_butterfly.sv */
`timescale 1ns/1ps

module fft_butterfly #(
    parameter int data_width = fft_pkg::sample_width
) (
    input  logic              clock,
    input  logic              arst_n,
    input  fft_pkg::cplx_t    a,
    input  fft_pkg::cplx_t    b,
    input  fft_pkg::twiddle_t twiddle,
    output fft_pkg::cplx_t    x,
    output fft_pkg::cplx_t    y
);

    typedef logic signed [data_width-1:0]  data_t;
    typedef logic signed [data_width:0]    sum_t;
    typedef logic signed [data_width+16:0] prod_t;

    data_t a_re;
    data_t a_im;
    data_t b_re;
    data_t b_im;

    prod_t t_re_full;
    prod_t t_im_full;
    data_t t_re;
    data_t t_im;

    sum_t  s_re;
    sum_t  s_im;
    sum_t  d_re;
    sum_t  d_im;

    // operands at the working width.
    assign a_re = data_t'(a.re);
    assign a_im = data_t'(a.im);
    assign b_re = data_t'(b.re);
    assign b_im = data_t'(b.im);

    // ------------------------------------------------------------------------
    // t = b * w at full precision and truncated back to Q0.
    // ------------------------------------------------------------------------
    assign t_re_full = prod_t'(b_re) * prod_t'(twiddle.re)
                     - prod_t'(b_im) * prod_t'(twiddle.im);
    assign t_im_full = prod_t'(b_re) * prod_t'(twiddle.im)
                     + prod_t'(b_im) * prod_t'(twiddle.re);

    assign t_re = data_t'(t_re_full >>> fft_pkg::coef_frac);
    assign t_im = data_t'(t_im_full >>> fft_pkg::coef_frac);

    // one guard bit for the sum that the halving drops again.
    assign s_re = sum_t'(a_re) + sum_t'(t_re);
    assign s_im = sum_t'(a_im) + sum_t'(t_im);
    assign d_re = sum_t'(a_re) - sum_t'(t_re);
    assign d_im = sum_t'(a_im) - sum_t'(t_im);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
            y <= '0;
        end else begin
            x.re <= fft_pkg::sample_t'(data_t'(s_re >>> 1));
            x.im <= fft_pkg::sample_t'(data_t'(s_im >>> 1));
            y.re <= fft_pkg::sample_t'(data_t'(d_re >>> 1));
            y.im <= fft_pkg::sample_t'(data_t'(d_im >>> 1));
        end
    end

endmodule

/* design/fft_data_mem.sv */
`timescale 1ns/1ps

module fft_data_mem #(
    parameter int data_width = fft_pkg::sample_width
) (
    input  logic                clock,
    input  fft_pkg::bfly_addr_t rd,
    input  logic                rd_en,
    input  fft_pkg::bfly_addr_t wr,
    input  logic                wr_a_en,
    input  logic                wr_b_en,
    input  fft_pkg::cplx_t      x,
    input  fft_pkg::cplx_t      y,
    output fft_pkg::cplx_t      a,
    output fft_pkg::cplx_t      b
);

    typedef logic signed [data_width-1:0] data_t;

    // stored at the working width.
    typedef struct packed {
        data_t re;
        data_t im;
    } word_t;

    word_t bank_mem [2][fft_pkg::fft_points];
    logic  wr_bank;

    function automatic word_t to_word(fft_pkg::cplx_t v);
        word_t w;
        w.re = data_t'(v.re);
        w.im = data_t'(v.im);
        return w;
    endfunction

    function automatic fft_pkg::cplx_t to_cplx(word_t w);
        fft_pkg::cplx_t v;
        v.re = fft_pkg::sample_t'(w.re);
        v.im = fft_pkg::sample_t'(w.im);
        return v;
    endfunction

    // writes go to the bank not being read.
    assign wr_bank = ~wr.bank;

    always_ff @(posedge clock) begin
        if (wr_a_en) begin
            bank_mem[wr_bank][wr.a] <= to_word(x);
        end
        if (wr_b_en) begin
            bank_mem[wr_bank][wr.b] <= to_word(y);
        end
        if (rd_en) begin
            a <= to_cplx(bank_mem[rd.bank][rd.a]);
            b <= to_cplx(bank_mem[rd.bank][rd.b]);
        end
    end

endmodule

/* design/fft_mem_arbiter.sv */
`timescale 1ns/1ps

module fft_mem_arbiter (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                busy,
    input  fft_pkg::bfly_addr_t eng_rd,
    input  logic                eng_rd_en,
    input  fft_pkg::bfly_addr_t eng_wr,
    input  logic                eng_wr_en,
    input  fft_pkg::cplx_t      eng_x,
    input  fft_pkg::cplx_t      eng_y,
    input  logic                wr_strobe,
    input  fft_pkg::addr_t      wr_addr,
    input  fft_pkg::cplx_t      wr_data,
    input  logic                rd_strobe,
    input  fft_pkg::addr_t      rd_addr,
    output fft_pkg::bfly_addr_t mem_rd,
    output logic                mem_rd_en,
    output fft_pkg::bfly_addr_t mem_wr,
    output logic                mem_wr_a_en,
    output logic                mem_wr_b_en,
    output fft_pkg::cplx_t      mem_x,
    output fft_pkg::cplx_t      mem_y,
    output logic                rd_valid,
    output logic                host_drop
);

    fft_pkg::addr_t wr_addr_rev;

    // dit input ordering.
    always_comb begin
        for (int i = 0; i < $bits(wr_addr); i++) begin
            wr_addr_rev[i] = wr_addr[$bits(wr_addr)-1-i];
        end
    end

    // engine owns the memory while busy.
    // host reads bank 1; host writes tag read bank 1 so they land in bank 0.
    assign mem_rd      = busy ? eng_rd : '{a: rd_addr, b: rd_addr, bank: 1'b1};
    assign mem_rd_en   = busy ? eng_rd_en : rd_strobe;
    assign mem_wr      = busy ? eng_wr : '{a: wr_addr_rev, b: wr_addr_rev, bank: 1'b1};
    assign mem_wr_a_en = busy ? eng_wr_en : wr_strobe;
    assign mem_wr_b_en = busy & eng_wr_en;
    assign mem_x       = busy ? eng_x : wr_data;
    assign mem_y       = eng_y;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid  <= 1'b0;
            host_drop <= 1'b0;
        end else begin
            rd_valid  <= rd_strobe & ~busy;
            host_drop <= (rd_strobe | wr_strobe) & busy;
        end
    end

endmodule

/* design/fft_pkg.sv */
package fft_pkg;

    // ------------------------------------------------------------------------
    // transform geometry.
    // ------------------------------------------------------------------------

    // 32 points in five radix-2 levels.
    localparam int fft_points = 32;
    localparam int fft_levels = 5;

    // default sample width and the 16-bit Q1.14 twiddle format.
    localparam int sample_width = 16;
    localparam int coef_width   = 16;
    localparam int coef_frac    = 14;

    // ------------------------------------------------------------------------
    // widths with a meaning.
    // ------------------------------------------------------------------------

    // sample address within a bank.
    typedef logic [$clog2(fft_points)-1:0] addr_t;

    // level number, 0 to fft_levels-1.
    typedef logic [2:0] level_t;

    // butterfly index within one level.
    typedef logic [$clog2(fft_points/2)-1:0] bfly_idx_t;

    // twiddle table index, W32^k for k below 16.
    typedef logic [$clog2(fft_points/2)-1:0] tw_idx_t;

    typedef logic signed [coef_width-1:0]   coef_t;
    typedef logic signed [sample_width-1:0] sample_t;

    // ------------------------------------------------------------------------
    // grouped signals.
    // ------------------------------------------------------------------------

    // memory word and butterfly operand.
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        coef_t re;
        coef_t im;
    } twiddle_t;

    // butterfly pair plus the bank it is read from.
    typedef struct packed {
        addr_t a;
        addr_t b;
        logic  bank;
    } bfly_addr_t;

    // address generator sequencing.
    typedef enum logic [1:0] {
        idle,
        run,
        drain,
        finish
    } agu_state_e;

endpackage

/* design/fft_top.sv */
`timescale 1ns/1ps

module fft_top #(
    parameter int data_width = fft_pkg::sample_width
) (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           start,
    input  logic           wr_strobe,
    input  fft_pkg::addr_t wr_addr,
    input  fft_pkg::cplx_t wr_data,
    input  logic           rd_strobe,
    input  fft_pkg::addr_t rd_addr,
    output fft_pkg::cplx_t rd_data,
    output logic           rd_valid,
    output logic           busy,
    output logic           done,
    output logic           host_drop
);

    // ------------------------------------------------------------------------
    // engine side.
    // ------------------------------------------------------------------------
    fft_pkg::bfly_addr_t eng_rd;
    logic                eng_rd_en;
    fft_pkg::tw_idx_t    tw_idx;
    fft_pkg::bfly_addr_t eng_wr;
    logic                eng_wr_en;
    fft_pkg::twiddle_t   twiddle;
    fft_pkg::cplx_t      op_a;
    fft_pkg::cplx_t      op_b;
    fft_pkg::cplx_t      bfly_x;
    fft_pkg::cplx_t      bfly_y;

    // arbitrated memory side.
    fft_pkg::bfly_addr_t mem_rd;
    logic                mem_rd_en;
    fft_pkg::bfly_addr_t mem_wr;
    logic                mem_wr_a_en;
    logic                mem_wr_b_en;
    fft_pkg::cplx_t      mem_x;
    fft_pkg::cplx_t      mem_y;

    fft_agu agu_i (
        .clock(clock), .arst_n(arst_n), .start(start),
        .rd_pair(eng_rd), .rd_en(eng_rd_en), .tw_idx(tw_idx),
        .wr_pair(eng_wr), .wr_en(eng_wr_en), .busy(busy), .done(done)
    );

    twiddle_rom rom_i (.clock(clock), .tw_idx(tw_idx), .twiddle(twiddle));

    fft_butterfly #(.data_width(data_width)) bfly_i (
        .clock(clock), .arst_n(arst_n), .a(op_a), .b(op_b),
        .twiddle(twiddle), .x(bfly_x), .y(bfly_y)
    );

    fft_mem_arbiter arb_i (
        .clock(clock), .arst_n(arst_n), .busy(busy),
        .eng_rd(eng_rd), .eng_rd_en(eng_rd_en), .eng_wr(eng_wr), .eng_wr_en(eng_wr_en),
        .eng_x(bfly_x), .eng_y(bfly_y),
        .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_strobe(rd_strobe), .rd_addr(rd_addr),
        .mem_rd(mem_rd), .mem_rd_en(mem_rd_en), .mem_wr(mem_wr),
        .mem_wr_a_en(mem_wr_a_en), .mem_wr_b_en(mem_wr_b_en),
        .mem_x(mem_x), .mem_y(mem_y), .rd_valid(rd_valid), .host_drop(host_drop)
    );

    fft_data_mem #(.data_width(data_width)) mem_i (
        .clock(clock), .rd(mem_rd), .rd_en(mem_rd_en), .wr(mem_wr),
        .wr_a_en(mem_wr_a_en), .wr_b_en(mem_wr_b_en), .x(mem_x), .y(mem_y),
        .a(op_a), .b(op_b)
    );

    // host results come out of read port a.
    assign rd_data = op_a;

endmodule

/* design/twiddle_rom.sv */
`timescale 1ns/1ps

module twiddle_rom (
    input  logic              clock,
    input  fft_pkg::tw_idx_t  tw_idx,
    output fft_pkg::twiddle_t twiddle
);

    fft_pkg::twiddle_t tw_value;

    // cos and -sin of 2*pi*k/32 in Q1.14.
    // +1.0 does not fit the positive range and is held at 16383.
    always_comb begin
        case (tw_idx)
            4'd0:    tw_value = '{re:  16'sd16383, im:  16'sd0};
            4'd1:    tw_value = '{re:  16'sd16069, im: -16'sd3196};
            4'd2:    tw_value = '{re:  16'sd15137, im: -16'sd6270};
            4'd3:    tw_value = '{re:  16'sd13623, im: -16'sd9102};
            4'd4:    tw_value = '{re:  16'sd11585, im: -16'sd11585};
            4'd5:    tw_value = '{re:  16'sd9102,  im: -16'sd13623};
            4'd6:    tw_value = '{re:  16'sd6270,  im: -16'sd15137};
            4'd7:    tw_value = '{re:  16'sd3196,  im: -16'sd16069};
            4'd8:    tw_value = '{re:  16'sd0,     im: -16'sd16384};
            4'd9:    tw_value = '{re: -16'sd3196,  im: -16'sd16069};
            4'd10:   tw_value = '{re: -16'sd6270,  im: -16'sd15137};
            4'd11:   tw_value = '{re: -16'sd9102,  im: -16'sd13623};
            4'd12:   tw_value = '{re: -16'sd11585, im: -16'sd11585};
            4'd13:   tw_value = '{re: -16'sd13623, im: -16'sd9102};
            4'd14:   tw_value = '{re: -16'sd15137, im: -16'sd6270};
            default: tw_value = '{re: -16'sd16069, im: -16'sd3196};
        endcase
    end

    // lines up with the data memory read.
    always_ff @(posedge clock) begin
        twiddle <= tw_value;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fft_tb -f verilog.f -o fft_tb_sim

# assertion failures are counted by the testbench, so the run goes on past them.
./obj_dir/fft_tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* verification/fft_chk.sv */
`timescale 1ns/1ps

module fft_chk (
    input logic                clock,
    input logic                arst_n,
    input logic                rd_strobe,
    input logic                rd_valid,
    input logic                busy,
    input logic                done,
    input fft_pkg::agu_state_e agu_state,
    input logic                agu_wr_en
);

    // failed assertions so far.
    int fail_count = 0;

    // done is a single-cycle pulse.
    done_width_a: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    // busy drops in exactly the cycle where done pulses.
    busy_fall_a: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(busy) |-> done)
        else begin
            fail_count++;
            $error("busy fell without done");
        end

    done_busy_a: assert property (@(posedge clock) disable iff (!arst_n)
        done |-> $fell(busy))
        else begin
            fail_count++;
            $error("done pulsed without busy falling");
        end

    // host read answers one cycle later when the engine is idle.
    rd_valid_a: assert property (@(posedge clock) disable iff (!arst_n)
        rd_strobe && !busy |=> rd_valid)
        else begin
            fail_count++;
            $error("rd_valid missing one cycle after rd_strobe");
        end

    wr_en_idle_a: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(agu_wr_en) |-> agu_state != fft_pkg::idle)
        else begin
            fail_count++;
            $error("engine write enable rose while the AGU was idle");
        end

endmodule

bind fft_top fft_chk chk_i (
    .clock(clock), .arst_n(arst_n), .rd_strobe(rd_strobe), .rd_valid(rd_valid),
    .busy(busy), .done(done), .agu_state(agu_i.state), .agu_wr_en(agu_i.wr_en)
);

/* verification/fft_tb.sv */
`timescale 1ns/1ps

module fft_tb;

    localparam int wait_limit = 200;

    logic           clock;
    logic           arst_n;
    logic           start;
    logic           wr_strobe;
    fft_pkg::addr_t wr_addr;
    fft_pkg::cplx_t wr_data;
    logic           rd_strobe;
    fft_pkg::addr_t rd_addr;
    fft_pkg::cplx_t rd_data;
    logic           rd_valid;
    logic           busy;
    logic           done;
    logic           host_drop;

    // frame in natural order and its expected spectrum.
    int in_re[32];
    int in_im[32];
    int exp_re[32];
    int exp_im[32];
    // bins requested but not yet returned.
    int pending[$];

    int error_count;
    int test_errors;
    int test_count;
    int failed_tests;
    bit timed_out;

    fft_top #(.data_width(16)) dut_i (
        .clock(clock), .arst_n(arst_n), .start(start),
        .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_strobe(rd_strobe), .rd_addr(rd_addr), .rd_data(rd_data),
        .rd_valid(rd_valid), .busy(busy), .done(done), .host_drop(host_drop)
    );

    always #50 clock = ~clock;

    // W32^k rounded to Q1.14 with +1.0 clipped to 16383.
    function automatic void twiddle_ref(input int k, output int w_re, output int w_im);
        real ang;
        ang  = 2.0 * 3.141592653589793 * real'(k) / 32.0;
        w_re = int'($cos(ang) * 16384.0);
        w_im = int'(-$sin(ang) * 16384.0);
        if (w_re > 16383) begin
            w_re = 16383;
        end
    endfunction

    function automatic int rotl5(input int v, input int s);
        return ((v << s) | (v >> (5 - s))) & 31;
    endfunction

    // ------------------------------------------------------------------------
    // radix-2 dit reference model with a halving at every level.
    // ------------------------------------------------------------------------
    function automatic void fft_ref();
        int     d_re[32];
        int     d_im[32];
        int     r;
        int     a;
        int     b;
        int     w_re;
        int     w_im;
        longint p_re;
        longint p_im;
        int     t_re;
        int     t_im;
        int     x_re;
        int     x_im;
        for (int i = 0; i < 32; i++) begin
            r = 0;
            for (int n = 0; n < 5; n++) begin
                r = r | (((i >> n) & 1) << (4 - n));
            end
            d_re[r] = in_re[i];
            d_im[r] = in_im[i];
        end
        for (int lvl = 0; lvl < 5; lvl++) begin
            for (int j = 0; j < 16; j++) begin
                a = rotl5(2 * j, lvl);
                b = rotl5(2 * j + 1, lvl);
                twiddle_ref((a % (1 << lvl)) << (4 - lvl), w_re, w_im);
                p_re = longint'(d_re[b]) * w_re - longint'(d_im[b]) * w_im;
                p_im = longint'(d_re[b]) * w_im + longint'(d_im[b]) * w_re;
                t_re = int'(shortint'(p_re >>> 14));
                t_im = int'(shortint'(p_im >>> 14));
                x_re = int'(shortint'((d_re[a] + t_re) >>> 1));
                x_im = int'(shortint'((d_im[a] + t_im) >>> 1));
                d_re[b] = int'(shortint'((d_re[a] - t_re) >>> 1));
                d_im[b] = int'(shortint'((d_im[a] - t_im) >>> 1));
                d_re[a] = x_re;
                d_im[a] = x_im;
            end
        end
        exp_re = d_re;
        exp_im = d_im;
    endfunction

    // results are sampled on the falling edge.
    always @(negedge clock) begin
        int idx;
        if (rd_valid) begin
            if (pending.size() == 0) begin
                $display("unexpected rd_valid at %0t with no read outstanding", $time);
                test_errors++;
            end else begin
                idx = pending.pop_front();
                if (rd_data.re !== fft_pkg::sample_t'(exp_re[idx]) ||
                    rd_data.im !== fft_pkg::sample_t'(exp_im[idx])) begin
                    $display("ERROR %0t: bin %0d is (%0d, %0d), expected (%0d, %0d)", $time,
                             idx, rd_data.re, rd_data.im, exp_re[idx], exp_im[idx]);
                    test_errors++;
                end
            end
        end
    end

    task automatic load_frame();
        for (int i = 0; i < 32; i++) begin
            @(posedge clock);
            #1;
            wr_strobe  = 1'b1;
            wr_addr    = fft_pkg::addr_t'(i);
            wr_data.re = fft_pkg::sample_t'(in_re[i]);
            wr_data.im = fft_pkg::sample_t'(in_im[i]);
        end
        @(posedge clock);
        #1;
        wr_strobe = 1'b0;
    endtask

    task automatic random_frame();
        for (int i = 0; i < 32; i++) begin
            in_re[i] = int'($urandom_range(32000)) - 16000;
            in_im[i] = int'($urandom_range(32000)) - 16000;
        end
        fft_ref();
    endtask

    task automatic pulse_start();
        @(posedge clock);
        #1;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
    endtask

    // counts cycles from the start edge to done and checks busy on the way.
    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!timed_out) begin
            @(negedge clock);
            if (done) begin
                break;
            end
            if (!busy) begin
                $display("ERROR %0t: busy low %0d cycles after start", $time, cycles);
                test_errors++;
            end
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout: no done within %0d cycles of start", wait_limit);
                timed_out = 1'b1;
            end
        end
        if (!timed_out && cycles != 90) begin
            $display("ERROR %0t: done after %0d cycles, expected 90", $time, cycles);
            test_errors++;
        end
    endtask

    // host write and read in the first busy cycle.
    task automatic drop_access();
        wr_strobe  = 1'b1;
        wr_addr    = 5'd3;
        wr_data.re = 16'sd1234;
        wr_data.im = -16'sd1234;
        rd_strobe  = 1'b1;
        rd_addr    = 5'd7;
        @(posedge clock);
        #1;
        wr_strobe = 1'b0;
        rd_strobe = 1'b0;
        @(negedge clock);
        if (!host_drop) begin
            $display("ERROR %0t: host_drop missing after an access while busy", $time);
            test_errors++;
        end
    endtask

    task automatic read_results();
        int waited;
        for (int i = 0; i < 32; i++) begin
            @(posedge clock);
            #1;
            rd_strobe = 1'b1;
            rd_addr   = fft_pkg::addr_t'(i);
            pending.push_back(i);
        end
        @(posedge clock);
        #1;
        rd_strobe = 1'b0;
        waited    = 0;
        while (pending.size() != 0 && !timed_out) begin
            @(negedge clock);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: %0d reads never returned rd_valid", pending.size());
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        error_count += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
            $display("test %s: %0d errors", name, test_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic run_frame(input string name, input bit with_drop);
        test_errors = 0;
        load_frame();
        pulse_start();
        fork
            wait_done();
            if (with_drop) drop_access();
        join
        if (!timed_out) begin
            read_results();
        end
        report_test(name);
    endtask

    initial begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        wr_strobe    = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        rd_strobe    = 1'b0;
        rd_addr      = '0;
        error_count  = 0;
        test_errors  = 0;
        test_count   = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        void'($urandom(32'h2df3));
        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;

        // an impulse gives 16000/32 in every bin.
        for (int i = 0; i < 32; i++) begin
            in_re[i]  = (i == 0) ? 16000 : 0;
            in_im[i]  = 0;
            exp_re[i] = 500;
            exp_im[i] = 0;
        end
        run_frame("impulse", 1'b0);

        for (int i = 0; i < 32; i++) begin
            in_re[i] = 8000;
            in_im[i] = 0;
        end
        fft_ref();
        if (!timed_out) begin
            run_frame("dc", 1'b0);
        end

        for (int f = 0; f < 10 && !timed_out; f++) begin
            random_frame();
            run_frame($sformatf("random frame %0d", f), 1'b0);
        end

        if (!timed_out) begin
            test_errors = 0;
            pulse_start();
            wait_done();
            report_test("done timing");
        end

        // the frame must survive the dropped write.
        if (!timed_out) begin
            random_frame();
            run_frame("dropped access", 1'b1);
        end

        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 test_count, failed_tests, error_count, dut_i.chk_i.fail_count);
        if (timed_out || error_count != 0 || dut_i.chk_i.fail_count != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/fft_pkg.sv
design/fft_agu.sv
design/twiddle_rom.sv
design/fft_butterfly.sv
design/fft_mem_arbiter.sv
design/fft_data_mem.sv
design/fft_top.sv
verification/fft_chk.sv
verification/fft_tb.sv
